//--- load_store_top.f
+incdir+sim
verilog/mem_pkg.sv
verilog/data_memory_interface.sv
verilog/bus_decoder.sv
verilog/data_memory.sv
verilog/io_registers.sv
verilog/load_store_top.sv
sim/tb_load_store.sv

//--- sim/tb_vectors.svh
////////////////////////////////////////
// load/store testbench step table
// one access per step with expected results
////////////////////////////////////////

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// what a step does on the bus
// pins checks gpio_out with no access
// mark samples the counter, delta checks cycles since mark
typedef enum logic [2:0] {
  op_store,
  op_load,
  op_idle,
  op_pins,
  op_mark,
  op_delta
} step_op_t;

// columns: test, op, format, address, write data, expected data, expected fault
typedef struct packed {
  logic [2:0]            test;
  step_op_t              op;
  mem_pkg::data_format_t fmt;
  logic [31:0]           address;
  logic [31:0]           wdata;
  logic [31:0]           exp_data;
  logic                  exp_fault;
} step_t;

localparam int step_count = 44;

localparam step_t step_table [step_count] = '{
  // ram word then partial stores, checked by word loads
  '{3'd1, op_store, mem_pkg::fmt_word, 32'h00000010, 32'h12345678, 32'h00000000, 1'b0},
  '{3'd1, op_load,  mem_pkg::fmt_word, 32'h00000010, 32'h00000000, 32'h12345678, 1'b0},
  '{3'd1, op_store, mem_pkg::fmt_byte, 32'h00000011, 32'h000000aa, 32'h00000000, 1'b0},
  '{3'd1, op_store, mem_pkg::fmt_half, 32'h00000012, 32'h0000beef, 32'h00000000, 1'b0},
  '{3'd1, op_load,  mem_pkg::fmt_word, 32'h00000010, 32'h00000000, 32'hbeefaa78, 1'b0},
  '{3'd1, op_store, mem_pkg::fmt_byte, 32'h00000010, 32'h00000011, 32'h00000000, 1'b0},
  '{3'd1, op_store, mem_pkg::fmt_byte, 32'h00000012, 32'h00000022, 32'h00000000, 1'b0},
  '{3'd1, op_store, mem_pkg::fmt_byte, 32'h00000013, 32'h00000033, 32'h00000000, 1'b0},
  '{3'd1, op_load,  mem_pkg::fmt_word, 32'h00000010, 32'h00000000, 32'h3322aa11, 1'b0},
  '{3'd1, op_store, mem_pkg::fmt_half, 32'h00000010, 32'h00004455, 32'h00000000, 1'b0},
  '{3'd1, op_load,  mem_pkg::fmt_word, 32'h00000010, 32'h00000000, 32'h33224455, 1'b0},
  // every byte and half has its top bit set
  '{3'd2, op_store, mem_pkg::fmt_word,   32'h00000020, 32'h8090a0f0, 32'h00000000, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_byte,   32'h00000020, 32'h00000000, 32'hfffffff0, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_byte_u, 32'h00000020, 32'h00000000, 32'h000000f0, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_byte,   32'h00000021, 32'h00000000, 32'hffffffa0, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_byte_u, 32'h00000021, 32'h00000000, 32'h000000a0, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_byte,   32'h00000022, 32'h00000000, 32'hffffff90, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_byte_u, 32'h00000022, 32'h00000000, 32'h00000090, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_byte,   32'h00000023, 32'h00000000, 32'hffffff80, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_byte_u, 32'h00000023, 32'h00000000, 32'h00000080, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_half,   32'h00000020, 32'h00000000, 32'hffffa0f0, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_half_u, 32'h00000020, 32'h00000000, 32'h0000a0f0, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_half,   32'h00000022, 32'h00000000, 32'hffff8090, 1'b0},
  '{3'd2, op_load,  mem_pkg::fmt_half_u, 32'h00000022, 32'h00000000, 32'h00008090, 1'b0},
  // gpio word, then one byte lane
  '{3'd3, op_store, mem_pkg::fmt_word,   32'h00010000, 32'hcafef00d, 32'h00000000, 1'b0},
  '{3'd3, op_pins,  mem_pkg::fmt_word,   32'h00000000, 32'h00000000, 32'hcafef00d, 1'b0},
  '{3'd3, op_store, mem_pkg::fmt_byte,   32'h00010002, 32'h00000055, 32'h00000000, 1'b0},
  '{3'd3, op_pins,  mem_pkg::fmt_word,   32'h00000000, 32'h00000000, 32'hca55f00d, 1'b0},
  '{3'd3, op_load,  mem_pkg::fmt_word,   32'h00010000, 32'h00000000, 32'hca55f00d, 1'b0},
  '{3'd3, op_load,  mem_pkg::fmt_byte_u, 32'h00010003, 32'h00000000, 32'h000000ca, 1'b0},
  // counter spacing, a write in between must not disturb it
  '{3'd4, op_mark,  mem_pkg::fmt_word, 32'h00010004, 32'h00000000, 32'h00000000, 1'b0},
  '{3'd4, op_idle,  mem_pkg::fmt_word, 32'h00000000, 32'h00000000, 32'h00000000, 1'b0},
  '{3'd4, op_idle,  mem_pkg::fmt_word, 32'h00000000, 32'h00000000, 32'h00000000, 1'b0},
  '{3'd4, op_delta, mem_pkg::fmt_word, 32'h00010004, 32'h00000000, 32'h00000003, 1'b0},
  '{3'd4, op_store, mem_pkg::fmt_word, 32'h00010004, 32'h00000000, 32'h00000000, 1'b0},
  '{3'd4, op_delta, mem_pkg::fmt_word, 32'h00010004, 32'h00000000, 32'h00000005, 1'b0},
  // unmapped accesses fault, read zero and write nothing
  '{3'd5, op_store, mem_pkg::fmt_word, 32'h00000000, 32'h13579bdf, 32'h00000000, 1'b0},
  '{3'd5, op_store, mem_pkg::fmt_word, 32'h00002000, 32'hffffffff, 32'h00000000, 1'b1},
  '{3'd5, op_store, mem_pkg::fmt_word, 32'h00010100, 32'hffffffff, 32'h00000000, 1'b1},
  '{3'd5, op_load,  mem_pkg::fmt_word, 32'h00002000, 32'h00000000, 32'h00000000, 1'b1},
  '{3'd5, op_load,  mem_pkg::fmt_byte, 32'hfffffffc, 32'h00000000, 32'h00000000, 1'b1},
  '{3'd5, op_load,  mem_pkg::fmt_word, 32'h00000000, 32'h00000000, 32'h13579bdf, 1'b0},
  '{3'd5, op_pins,  mem_pkg::fmt_word, 32'h00000000, 32'h00000000, 32'hca55f00d, 1'b0},
  '{3'd5, op_load,  mem_pkg::fmt_word, 32'h00010000, 32'h00000000, 32'hca55f00d, 1'b0}
};

`endif

//--- sim/tb_load_store.sv
////////////////////////////////////////
// load/store testbench
// table-driven directed steps, then a
// random ram pass against a byte model
////////////////////////////////////////

`timescale 1ns/1ps

module tb_load_store;

  `include "tb_vectors.svh"

  localparam int rand_count = 200;
  // two cycles per table step plus the random pass and slack
  localparam int max_cycles = 2 * step_count + rand_count + 100;
  // random pass region, clear of the table addresses
  localparam logic [31:0] rand_base = 32'h0000_0400;

  logic                  clk;
  logic                  rst_n;
  logic                  read_enable;
  logic                  write_enable;
  mem_pkg::data_format_t data_format;
  logic [31:0]           address;
  logic [31:0]           write_data;
  logic [31:0]           read_data;
  logic [31:0]           gpio_out;
  logic                  access_fault;

  int          seed;
  int          error_count;
  int          check_count;
  int          cycle_count;
  // values taken just before the next edge
  logic [31:0] sampled_data;
  logic [31:0] sampled_gpio;
  logic        sampled_fault;
  logic [31:0] mark_value;
  // byte model of the random region
  logic [7:0]  ref_mem [256];
  logic        ref_known [256];

  load_store_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .read_enable  (read_enable),
    .write_enable (write_enable),
    .data_format  (data_format),
    .address      (address),
    .write_data   (write_data),
    .read_data    (read_data),
    .gpio_out     (gpio_out),
    .access_fault (access_fault)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // one bus cycle, drive 2 ns after the edge, sample 2 ns before the next
  task automatic run_step(input step_op_t op, input mem_pkg::data_format_t fmt,
                          input logic [31:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    #2;
    write_enable = (op == op_store);
    read_enable  = (op == op_load) || (op == op_mark) || (op == op_delta);
    data_format  = fmt;
    address      = addr;
    write_data   = wdata;
    #16;
    sampled_data  = read_data;
    sampled_gpio  = gpio_out;
    sampled_fault = access_fault;
  endtask

  task automatic report_test(input int test, input int errors);
    $display("test %0d finished: %0d mismatches", test, errors);
  endtask

  // expected load from the byte model, extended per format bit 2
  function automatic logic [31:0] predict_load(input mem_pkg::data_format_t fmt,
                                               input int offset);
    logic        fill;
    logic [15:0] half;
    case (fmt[1:0])
      2'b00: begin
        fill = ~fmt[2] & ref_mem[offset][7];
        return {{24{fill}}, ref_mem[offset]};
      end
      2'b01: begin
        half = {ref_mem[offset + 1], ref_mem[offset]};
        fill = ~fmt[2] & half[15];
        return {{16{fill}}, half};
      end
      default: begin
        return {ref_mem[offset + 3], ref_mem[offset + 2],
                ref_mem[offset + 1], ref_mem[offset]};
      end
    endcase
  endfunction

  task automatic random_pass();
    int                    pick;
    int                    size;
    int                    offset;
    logic                  all_known;
    logic [31:0]           wdata;
    mem_pkg::data_format_t fmt;
    for (int k = 0; k < 256; k++) begin
      ref_known[k] = 1'b0;
    end
    for (int i = 0; i < rand_count; i++) begin
      pick = $unsigned($random(seed)) % 5;
      case (pick)
        0: fmt = mem_pkg::fmt_byte;
        1: fmt = mem_pkg::fmt_half;
        2: fmt = mem_pkg::fmt_word;
        3: fmt = mem_pkg::fmt_byte_u;
        default: fmt = mem_pkg::fmt_half_u;
      endcase
      size   = 1 << fmt[1:0];
      // aligned to the access size
      offset = $unsigned($random(seed)) % 256;
      offset = offset - (offset % size);
      wdata  = $random(seed);
      all_known = 1'b1;
      for (int k = 0; k < size; k++) begin
        if (!ref_known[offset + k]) begin
          all_known = 1'b0;
        end
      end
      pick = $random(seed);
      // a load of bytes never written turns into a store
      if (pick[0] && all_known) begin
        run_step(op_load, fmt, rand_base + offset, 32'h0);
        check_value("read_data", sampled_data, predict_load(fmt, offset));
      end else begin
        run_step(op_store, fmt, rand_base + offset, wdata);
        for (int k = 0; k < size; k++) begin
          ref_mem[offset + k]   = wdata[8 * k +: 8];
          ref_known[offset + k] = 1'b1;
        end
      end
      check_value("access_fault", {31'b0, sampled_fault}, 32'h0);
    end
  endtask

  initial begin
    step_t entry;
    int    test_start;
    int    current_test;
    seed         = 97410;
    error_count  = 0;
    check_count  = 0;
    cycle_count  = 0;
    mark_value   = 32'h0;
    rst_n        = 1'b0;
    read_enable  = 1'b0;
    write_enable = 1'b0;
    data_format  = mem_pkg::fmt_word;
    address      = 32'h0;
    write_data   = 32'h0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    current_test = step_table[0].test;
    test_start   = error_count;
    for (int i = 0; i < step_count; i++) begin
      entry = step_table[i];
      if (entry.test != current_test) begin
        report_test(current_test, error_count - test_start);
        current_test = entry.test;
        test_start   = error_count;
      end
      run_step(entry.op, entry.fmt, entry.address, entry.wdata);
      case (entry.op)
        op_pins:  check_value("gpio_out", sampled_gpio, entry.exp_data);
        op_mark:  mark_value = sampled_data;
        op_delta: check_value("counter delta", sampled_data - mark_value, entry.exp_data);
        default:  check_value("read_data", sampled_data, entry.exp_data);
      endcase
      check_value("access_fault", {31'b0, sampled_fault}, {31'b0, entry.exp_fault});
    end
    report_test(current_test, error_count - test_start);

    test_start = error_count;
    random_pass();
    report_test(6, error_count - test_start);
    run_step(op_idle, mem_pkg::fmt_word, 32'h0, 32'h0);

    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verilog/load_store_top.sv
////////////////////////////////////////
// load/store top
// interface, decoder, ram and i/o block
////////////////////////////////////////

`timescale 1ns/1ps

module load_store_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // core access
  input  logic                  read_enable,
  input  logic                  write_enable,
  input  mem_pkg::data_format_t data_format,
  input  logic [31:0]           address,
  input  logic [31:0]           write_data,
  // results
  output logic [31:0]           read_data,
  output logic [31:0]           gpio_out,
  output logic                  access_fault
);

  // request out of the interface
  mem_pkg::mem_req_t cpu_req;
  // gated requests per target
  mem_pkg::mem_req_t ram_req;
  mem_pkg::mem_req_t io_req;
  // read words back
  logic [31:0]       ram_read_data;
  logic [31:0]       io_read_data;
  logic [31:0]       bus_read_data;

  // lane alignment and load extension
  data_memory_interface u_dmi (
    .read_enable   (read_enable),
    .write_enable  (write_enable),
    .data_format   (data_format),
    .address       (address),
    .write_data    (write_data),
    .bus_read_data (bus_read_data),
    .cpu_req       (cpu_req),
    .read_data     (read_data)
  );

  // address decode
  bus_decoder u_decoder (
    .cpu_req       (cpu_req),
    .ram_read_data (ram_read_data),
    .io_read_data  (io_read_data),
    .ram_req       (ram_req),
    .io_req        (io_req),
    .bus_read_data (bus_read_data),
    .access_fault  (access_fault)
  );

  // 4 KiB data ram
  data_memory u_ram (
    .clk           (clk),
    .ram_req       (ram_req),
    .ram_read_data (ram_read_data)
  );

  // gpio and cycle counter
  io_registers u_io (
    .clk           (clk),
    .rst_n         (rst_n),
    .io_req        (io_req),
    .io_read_data  (io_read_data),
    .gpio_out      (gpio_out)
  );

endmodule

//--- verilog/io_registers.sv
////////////////////////////////////////
// i/o registers
// byte-writable gpio output and a
// read-only free-running cycle counter
////////////////////////////////////////

`timescale 1ns/1ps

module io_registers (
  input  logic              clk,
  input  logic              rst_n,
  input  mem_pkg::mem_req_t io_req,
  output logic [31:0]       io_read_data,
  output logic [31:0]       gpio_out
);

  logic [31:0] gpio_reg;
  logic [31:0] cycle_count;
  // word offset from the window base
  logic [31:0] word_offset;
  logic        gpio_hit;
  logic        count_hit;

  assign word_offset = {io_req.address[31:2], 2'b00} - mem_pkg::io_base;
  assign gpio_hit    = (word_offset == mem_pkg::io_gpio_offset);
  assign count_hit   = (word_offset == mem_pkg::io_count_offset);

  // gpio register, one byte per lane enable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_reg <= 32'h0;
    end else if (io_req.write_enable && gpio_hit) begin
      if (io_req.byte_enable[0]) begin
        gpio_reg[7:0] <= io_req.write_data[7:0];
      end
      if (io_req.byte_enable[1]) begin
        gpio_reg[15:8] <= io_req.write_data[15:8];
      end
      if (io_req.byte_enable[2]) begin
        gpio_reg[23:16] <= io_req.write_data[23:16];
      end
      if (io_req.byte_enable[3]) begin
        gpio_reg[31:24] <= io_req.write_data[31:24];
      end
    end
  end

  // cycle counter
  // zero in the first cycle out of reset, then +1 per clock
  // a write to its offset falls through, nothing is decoded for it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cycle_count <= 32'h0;
    end else begin
      cycle_count <= cycle_count + 32'd1;
    end
  end

  // read mux
  always_comb begin
    if (!io_req.read_enable) begin
      io_read_data = 32'h0;
    end else if (gpio_hit) begin
      io_read_data = gpio_reg;
    end else if (count_hit) begin
      io_read_data = cycle_count;
    end else begin
      // rest of the window is empty
      io_read_data = 32'h0;
    end
  end

  // pin side
  assign gpio_out = gpio_reg;

endmodule

//--- verilog/data_memory.sv
////////////////////////////////////////
// data ram
// word array, per-byte write, comb read
////////////////////////////////////////

`timescale 1ns/1ps

module data_memory (
  input  logic              clk,
  input  mem_pkg::mem_req_t ram_req,
  output logic [31:0]       ram_read_data
);

  // storage, contents undefined after reset
  logic [31:0] mem [mem_pkg::ram_words];

  // word index from address bits 11:2
  logic [mem_pkg::ram_index_bits-1:0] word_index;

  assign word_index = ram_req.address[mem_pkg::ram_index_bits+1:2];

  // byte lane writes
  always_ff @(posedge clk) begin
    if (ram_req.write_enable) begin
      // lane 0
      if (ram_req.byte_enable[0]) begin
        mem[word_index][7:0] <= ram_req.write_data[7:0];
      end
      // lane 1
      if (ram_req.byte_enable[1]) begin
        mem[word_index][15:8] <= ram_req.write_data[15:8];
      end
      // lane 2
      if (ram_req.byte_enable[2]) begin
        mem[word_index][23:16] <= ram_req.write_data[23:16];
      end
      // lane 3
      if (ram_req.byte_enable[3]) begin
        mem[word_index][31:24] <= ram_req.write_data[31:24];
      end
    end
  end

  // read in the same cycle
  // a store shows up here from the next cycle on
  always_comb begin
    if (ram_req.read_enable) begin
      ram_read_data = mem[word_index];
    end else begin
      // idle bus reads zero
      ram_read_data = 32'h0;
    end
  end

endmodule

//--- verilog/bus_decoder.sv
////////////////////////////////////////
// bus decoder
// routes a request to ram, i/o or nowhere
////////////////////////////////////////

`timescale 1ns/1ps

module bus_decoder (
  input  mem_pkg::mem_req_t cpu_req,
  // read words from each target
  input  logic [31:0]       ram_read_data,
  input  logic [31:0]       io_read_data,
  // per-target requests
  output mem_pkg::mem_req_t ram_req,
  output mem_pkg::mem_req_t io_req,
  output logic [31:0]       bus_read_data,
  output logic              access_fault
);

  mem_pkg::target_t target_sel;
  logic             in_ram_window;
  logic             in_io_window;

  // window compare on the full address
  assign in_ram_window = (cpu_req.address >= mem_pkg::ram_base) &&
                         (cpu_req.address <= mem_pkg::ram_limit);
  assign in_io_window  = (cpu_req.address >= mem_pkg::io_base) &&
                         (cpu_req.address <= mem_pkg::io_limit);

  always_comb begin
    if (in_ram_window) begin
      target_sel = mem_pkg::target_ram;
    end else if (in_io_window) begin
      target_sel = mem_pkg::target_io;
    end else begin
      target_sel = mem_pkg::target_none;
    end
  end

  // address, data and lanes go to both targets
  // only the selected one sees its enables
  always_comb begin
    ram_req              = cpu_req;
    ram_req.read_enable  = cpu_req.read_enable  && (target_sel == mem_pkg::target_ram);
    ram_req.write_enable = cpu_req.write_enable && (target_sel == mem_pkg::target_ram);

    io_req               = cpu_req;
    io_req.read_enable   = cpu_req.read_enable  && (target_sel == mem_pkg::target_io);
    io_req.write_enable  = cpu_req.write_enable && (target_sel == mem_pkg::target_io);
  end

  // read return
  always_comb begin
    case (target_sel)
      mem_pkg::target_ram: bus_read_data = ram_read_data;
      mem_pkg::target_io:  bus_read_data = io_read_data;
      // unmapped reads zero
      default:             bus_read_data = 32'h0;
    endcase
  end

  // fault only for an actual access
  assign access_fault = (cpu_req.read_enable || cpu_req.write_enable) &&
                        (target_sel == mem_pkg::target_none);

endmodule

//--- verilog/data_memory_interface.sv
////////////////////////////////////////
// data memory interface
// lane alignment of stores, byte enables,
// load extraction and sign extension
////////////////////////////////////////

`timescale 1ns/1ps

module data_memory_interface (
  // core side
  input  logic                  read_enable,
  input  logic                  write_enable,
  input  mem_pkg::data_format_t data_format,
  input  logic [31:0]           address,
  input  logic [31:0]           write_data,
  // word returned by the decoder
  input  logic [31:0]           bus_read_data,
  // request towards the decoder
  output mem_pkg::mem_req_t     cpu_req,
  output logic [31:0]           read_data
);

  // byte offset inside the word
  logic [1:0]  byte_offset;
  // load word with the addressed byte moved to lane 0
  logic [31:0] load_shifted;
  // high bits filled with the sign unless unsigned
  logic        fill_bit_byte;
  logic        fill_bit_half;

  assign byte_offset = address[1:0];

  // request side
  always_comb begin
    cpu_req.address      = address;
    cpu_req.read_enable  = read_enable;
    cpu_req.write_enable = write_enable;
    // move store data up to its lane
    // bytes pushed past lane 3 are lost
    cpu_req.write_data   = write_data << {byte_offset, 3'b000};

    case (data_format[1:0])
      mem_pkg::fmt_byte[1:0]: cpu_req.byte_enable = 4'b0001 << byte_offset;
      mem_pkg::fmt_half[1:0]: cpu_req.byte_enable = 4'b0011 << byte_offset;
      mem_pkg::fmt_word[1:0]: cpu_req.byte_enable = 4'b1111 << byte_offset;
      // invalid size, no lanes touched
      default:                cpu_req.byte_enable = 4'b0000;
    endcase
  end

  // load side
  assign load_shifted  = bus_read_data >> {byte_offset, 3'b000};
  // bit 2 of the format set means zero fill
  assign fill_bit_byte = ~data_format[2] & load_shifted[7];
  assign fill_bit_half = ~data_format[2] & load_shifted[15];

  always_comb begin
    case (data_format[1:0])
      mem_pkg::fmt_byte[1:0]: read_data = {{24{fill_bit_byte}}, load_shifted[7:0]};
      mem_pkg::fmt_half[1:0]: read_data = {{16{fill_bit_half}}, load_shifted[15:0]};
      mem_pkg::fmt_word[1:0]: read_data = load_shifted;
      // invalid size reads zero
      default:                read_data = 32'h0;
    endcase
  end

endmodule

//--- verilog/mem_pkg.sv
////////////////////////////////////////
// load/store memory map package
// bus request struct, data format codes,
// window addresses and ram sizing
////////////////////////////////////////

package mem_pkg;

  // load/store format
  // bits 1:0 select the size, bit 2 asks for a zero-filled load
  typedef logic [2:0] data_format_t;

  localparam data_format_t fmt_byte   = 3'b000;
  localparam data_format_t fmt_half   = 3'b001;
  localparam data_format_t fmt_word   = 3'b010;
  localparam data_format_t fmt_byte_u = 3'b100;
  localparam data_format_t fmt_half_u = 3'b101;
  // size code 2'b11 is left unnamed
  // it enables no lanes and loads zero

  // request as seen by every target
  typedef struct packed {
    logic [31:0] address;
    logic [31:0] write_data;
    // one bit per byte lane, lane 0 is bits 7:0
    logic [3:0]  byte_enable;
    logic        read_enable;
    logic        write_enable;
  } mem_req_t;

  // data ram sizing
  localparam int ram_words      = 1024;
  localparam int ram_index_bits = 10;

  // ram window, 4 KiB from zero
  localparam logic [31:0] ram_base  = 32'h0000_0000;
  localparam logic [31:0] ram_limit = 32'h0000_0FFF;

  // i/o window, 256 bytes
  localparam logic [31:0] io_base  = 32'h0001_0000;
  localparam logic [31:0] io_limit = 32'h0001_00FF;

  // register word offsets inside the i/o window
  localparam logic [31:0] io_gpio_offset  = 32'h0000_0000;
  localparam logic [31:0] io_count_offset = 32'h0000_0004;

  // decoder target select
  typedef enum logic [1:0] {
    target_ram  = 2'b00,
    target_io   = 2'b01,
    target_none = 2'b10
  } target_t;

  // idle request
  // handy as a default before field overrides
  localparam mem_req_t mem_req_idle = '{
    address:      32'h0,
    write_data:   32'h0,
    byte_enable:  4'h0,
    read_enable:  1'b0,
    write_enable: 1'b0
  };

endpackage
